// File: design/axi_copy_pkg.sv
/*
 * Shared widths, AXI channel structs, request/response bundles and
 * the response codes used by the copy engine
 */

package axi_copy_pkg;

  // --------------------------------------------------------------------------
  // Widths and sizes
  // --------------------------------------------------------------------------
  localparam int unsigned AddrWidth    = 16;
  localparam int unsigned DataWidth    = 32;
  localparam int unsigned StrbWidth    = DataWidth / 8;
  localparam int unsigned IdWidth      = 2;
  // Job length 1..16 words, so 5 bits
  localparam int unsigned MaxBeats     = 16;
  localparam int unsigned LenWidth     = 5;
  // A whole burst fits so the reader never stalls on full
  localparam int unsigned FifoDepth    = 16;
  localparam int unsigned FifoPtrWidth = $clog2(FifoDepth);

  // Scalar types
  typedef logic [AddrWidth-1:0] axi_addr_t;
  typedef logic [DataWidth-1:0] axi_data_t;
  typedef logic [IdWidth-1:0]   axi_id_t;
  typedef logic [LenWidth-1:0]  axi_len_t;

  // Fixed field values
  localparam axi_id_t    ReadId     = 2'd1;
  localparam axi_id_t    WriteId    = 2'd2;
  localparam logic [2:0] Size4Bytes = 3'd2;
  localparam logic [1:0] BurstIncr  = 2'b01;
  localparam logic [1:0] RespOkay   = 2'b00;
  localparam logic [1:0] RespSlvErr = 2'b10;

  // --------------------------------------------------------------------------
  // Channel payloads
  // --------------------------------------------------------------------------
  typedef struct packed {
    axi_id_t    id;
    axi_addr_t  addr;
    logic [7:0] len;
    logic [2:0] size;
    logic [1:0] burst;
  } axi_aw_t;

  typedef struct packed {
    axi_id_t    id;
    axi_addr_t  addr;
    logic [7:0] len;
    logic [2:0] size;
    logic [1:0] burst;
  } axi_ar_t;

  typedef struct packed {
    axi_data_t            data;
    logic [StrbWidth-1:0] strb;
    logic                 last;
  } axi_w_t;

  typedef struct packed {
    axi_id_t    id;
    logic [1:0] resp;
  } axi_b_t;

  typedef struct packed {
    axi_id_t    id;
    axi_data_t  data;
    logic [1:0] resp;
    logic       last;
  } axi_r_t;

  // Master driven bundle
  typedef struct packed {
    axi_aw_t aw;
    logic    aw_valid;
    axi_w_t  w;
    logic    w_valid;
    logic    b_ready;
    axi_ar_t ar;
    logic    ar_valid;
    logic    r_ready;
  } axi_req_t;

  // Slave driven bundle
  typedef struct packed {
    logic   aw_ready;
    logic   ar_ready;
    logic   w_ready;
    axi_b_t b;
    logic   b_valid;
    axi_r_t r;
    logic   r_valid;
  } axi_resp_t;

endpackage : axi_copy_pkg

// File: design/axi_rw_join.sv
/*
 * Read/write join that merges a read-only and a write-only AXI master
 * into one read/write master port
 */

`timescale 1ns/1ps

module axi_rw_join #(
  parameter type axi_req_t  = logic,
  parameter type axi_resp_t = logic
) (
  // Only used by the assertions
  input  logic      clk_i,
  input  logic      rst_n_i,
  // Read side
  input  axi_req_t  slv_read_req_i,
  output axi_resp_t slv_read_resp_o,
  // Write side
  input  axi_req_t  slv_write_req_i,
  output axi_resp_t slv_write_resp_o,
  // Merged master
  output axi_req_t  mst_req_o,
  input  axi_resp_t mst_resp_i
);

  // --------------------------------------------------------------------------
  // Master request
  // --------------------------------------------------------------------------
  // AR and R handshake from the read side
  assign mst_req_o.ar       = slv_read_req_i.ar;
  assign mst_req_o.ar_valid = slv_read_req_i.ar_valid;
  assign mst_req_o.r_ready  = slv_read_req_i.r_ready;
  // AW, W and B handshake from the write side
  assign mst_req_o.aw       = slv_write_req_i.aw;
  assign mst_req_o.aw_valid = slv_write_req_i.aw_valid;
  assign mst_req_o.w        = slv_write_req_i.w;
  assign mst_req_o.w_valid  = slv_write_req_i.w_valid;
  assign mst_req_o.b_ready  = slv_write_req_i.b_ready;

  // --------------------------------------------------------------------------
  // Read side response
  // --------------------------------------------------------------------------
  assign slv_read_resp_o.ar_ready = mst_resp_i.ar_ready;
  assign slv_read_resp_o.r        = mst_resp_i.r;
  assign slv_read_resp_o.r_valid  = mst_resp_i.r_valid;
  // Write channels never answer the reader
  assign slv_read_resp_o.aw_ready = 1'b0;
  assign slv_read_resp_o.w_ready  = 1'b0;
  assign slv_read_resp_o.b        = '0;
  assign slv_read_resp_o.b_valid  = 1'b0;

  // --------------------------------------------------------------------------
  // Write side response
  // --------------------------------------------------------------------------
  assign slv_write_resp_o.aw_ready = mst_resp_i.aw_ready;
  assign slv_write_resp_o.w_ready  = mst_resp_i.w_ready;
  assign slv_write_resp_o.b        = mst_resp_i.b;
  assign slv_write_resp_o.b_valid  = mst_resp_i.b_valid;
  // Read channels tied off
  assign slv_write_resp_o.ar_ready = 1'b0;
  assign slv_write_resp_o.r        = '0;
  assign slv_write_resp_o.r_valid  = 1'b0;

  // Dropped traffic on an idle channel would hang the merged port
  read_side_no_write : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(slv_read_req_i.aw_valid || slv_read_req_i.w_valid));
  write_side_no_read : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !slv_write_req_i.ar_valid);

endmodule : axi_rw_join

// File: design/copy_reader.sv
/*
 * Read half of the copy engine with one INCR read burst, beats pushed
 * into the FIFO and a sticky error flag on a bad read response
 */

`timescale 1ns/1ps

module copy_reader import axi_copy_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  // Job fields held by the top for the whole job
  input  logic      start_i,
  input  axi_addr_t src_addr_i,
  input  axi_len_t  len_i,
  // Read-only AXI master
  output axi_req_t  axi_req_o,
  input  axi_resp_t axi_resp_i,
  // FIFO write side
  output logic      push_o,
  output axi_data_t push_data_o,
  input  logic      full_i,
  output logic      rd_err_o
);

  typedef enum logic [1:0] {
    st_idle,
    st_addr,
    st_data
  } state_e;

  state_e state_q;
  logic   r_fire;
  logic   rd_err_q;

  // One R beat moves when the FIFO has room
  assign r_fire = (state_q == st_data) && axi_resp_i.r_valid && !full_i;

  // --------------------------------------------------------------------------
  // FSM and error flag
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q  <= st_idle;
      rd_err_q <= 1'b0;
    end else begin
      unique case (state_q)
        st_idle: begin
          if (start_i) begin
            state_q  <= st_addr;
            // Error of the previous job cleared here
            rd_err_q <= 1'b0;
          end
        end
        st_addr: begin
          if (axi_resp_i.ar_ready) begin
            state_q <= st_data;
          end
        end
        st_data: begin
          if (r_fire) begin
            if (axi_resp_i.r.resp != RespOkay) begin
              rd_err_q <= 1'b1;
            end
            if (axi_resp_i.r.last) begin
              state_q <= st_idle;
            end
          end
        end
        default: state_q <= st_idle;
      endcase
    end
  end

  // --------------------------------------------------------------------------
  // AXI request with only AR and R active
  // --------------------------------------------------------------------------
  always_comb begin
    axi_req_o          = '0;
    axi_req_o.ar.id    = ReadId;
    axi_req_o.ar.addr  = src_addr_i;
    // AXI len counts beats minus one
    axi_req_o.ar.len   = 8'(len_i) - 8'd1;
    axi_req_o.ar.size  = Size4Bytes;
    axi_req_o.ar.burst = BurstIncr;
    axi_req_o.ar_valid = (state_q == st_addr);
    axi_req_o.r_ready  = (state_q == st_data) && !full_i;
  end

  // Beat data straight into the FIFO
  assign push_o      = r_fire;
  assign push_data_o = axi_resp_i.r.data;
  assign rd_err_o    = rd_err_q;

  // AR and its job payload must not change before the slave takes it
  ar_valid_hold : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    axi_req_o.ar_valid && !axi_resp_i.ar_ready |=>
      axi_req_o.ar_valid && $stable(axi_req_o.ar));

endmodule : copy_reader

// File: design/copy_fifo.sv
/*
 * First-word-fall-through FIFO between reader and writer
 */

`timescale 1ns/1ps

module copy_fifo import axi_copy_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      push_i,
  input  axi_data_t data_i,
  input  logic      pop_i,
  output axi_data_t data_o,
  output logic      empty_o,
  output logic      full_o
);

  axi_data_t               mem_q [FifoDepth];
  logic [FifoPtrWidth-1:0] wr_ptr_q;
  logic [FifoPtrWidth-1:0] rd_ptr_q;
  logic [FifoPtrWidth:0]   count_q;

  // Word storage
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // Pointers wrap naturally on a power of two depth
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      // Push and pop together keep the count
      count_q <= count_q + (FifoPtrWidth+1)'(push_i) - (FifoPtrWidth+1)'(pop_i);
    end
  end

  // Head word visible without a pop
  assign data_o  = mem_q[rd_ptr_q];
  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == (FifoPtrWidth+1)'(FifoDepth));

  no_push_full : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    push_i |-> !full_o);
  no_pop_empty : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pop_i |-> !empty_o);

endmodule : copy_fifo

// File: design/copy_writer.sv
/*
 * Write half of the copy engine with one INCR write burst fed from the
 * FIFO, write response collection and the job done strobe
 */

`timescale 1ns/1ps

module copy_writer import axi_copy_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  // Job fields held by the top for the whole job
  input  logic      start_i,
  input  axi_addr_t dst_addr_i,
  input  axi_len_t  len_i,
  input  logic      rd_err_i,
  // FIFO read side
  input  logic      empty_i,
  output logic      pop_o,
  input  axi_data_t pop_data_i,
  // Write-only AXI master
  output axi_req_t  axi_req_o,
  input  axi_resp_t axi_resp_i,
  // Job completion
  output logic      done_o,
  output logic      err_o
);

  typedef enum logic [2:0] {
    st_idle,
    st_addr,
    st_data,
    st_resp,
    st_done
  } state_e;

  state_e   state_q;
  axi_len_t beat_q;
  logic     last_beat;
  logic     w_fire;
  logic     err_q;

  // Beat counter runs 1..len_i
  assign last_beat = (beat_q == len_i);
  assign w_fire    = (state_q == st_data) && !empty_i && axi_resp_i.w_ready;

  // --------------------------------------------------------------------------
  // FSM, beat counter and error
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= st_idle;
      beat_q  <= '0;
      err_q   <= 1'b0;
    end else begin
      unique case (state_q)
        st_idle: begin
          if (start_i) begin
            state_q <= st_addr;
            beat_q  <= axi_len_t'(1);
          end
        end
        st_addr: begin
          if (axi_resp_i.aw_ready) begin
            state_q <= st_data;
          end
        end
        st_data: begin
          if (w_fire) begin
            if (last_beat) begin
              state_q <= st_resp;
            end else begin
              beat_q <= beat_q + 1'b1;
            end
          end
        end
        st_resp: begin
          if (axi_resp_i.b_valid) begin
            state_q <= st_done;
            // Read error folded in since the reader finished long before B
            err_q   <= (axi_resp_i.b.resp != RespOkay) || rd_err_i;
          end
        end
        st_done: state_q <= st_idle;
        default: state_q <= st_idle;
      endcase
    end
  end

  // --------------------------------------------------------------------------
  // AXI request with only AW, W and B active
  // --------------------------------------------------------------------------
  always_comb begin
    axi_req_o          = '0;
    axi_req_o.aw.id    = WriteId;
    axi_req_o.aw.addr  = dst_addr_i;
    axi_req_o.aw.len   = 8'(len_i) - 8'd1;
    axi_req_o.aw.size  = Size4Bytes;
    axi_req_o.aw.burst = BurstIncr;
    axi_req_o.aw_valid = (state_q == st_addr);
    // W data from the FIFO head with full word strobes
    axi_req_o.w.data   = pop_data_i;
    axi_req_o.w.strb   = '1;
    axi_req_o.w.last   = last_beat;
    axi_req_o.w_valid  = (state_q == st_data) && !empty_i;
    axi_req_o.b_ready  = (state_q == st_resp);
  end

  assign pop_o  = w_fire;
  assign done_o = (state_q == st_done);
  assign err_o  = err_q;

  // An offered W beat keeps its FIFO head data until the slave takes it
  w_valid_hold : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    axi_req_o.w_valid && !axi_resp_i.w_ready |=>
      axi_req_o.w_valid && $stable(axi_req_o.w));

endmodule : copy_writer

// File: design/axi_copy_top.sv
/*
 * Copy engine top with job registers, busy flag, reader, FIFO, writer
 * and the read/write join onto one AXI master port
 */

`timescale 1ns/1ps

module axi_copy_top import axi_copy_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  // Job interface
  input  logic      start_i,
  input  axi_addr_t src_addr_i,
  input  axi_addr_t dst_addr_i,
  input  axi_len_t  len_i,
  output logic      busy_o,
  output logic      done_o,
  output logic      err_o,
  // AXI master
  output axi_req_t  mst_req_o,
  input  axi_resp_t mst_resp_i
);

  axi_addr_t src_q;
  axi_addr_t dst_q;
  axi_len_t  len_q;
  logic      busy_q;
  logic      go_q;
  logic      accept;
  logic      wr_done;
  logic      rd_err;
  logic      push;
  logic      pop;
  logic      fifo_empty;
  logic      fifo_full;
  axi_data_t push_data;
  axi_data_t pop_data;
  axi_req_t  rd_req;
  axi_resp_t rd_resp;
  axi_req_t  wr_req;
  axi_resp_t wr_resp;

  // Busy drops in the done cycle so a new start may land there
  assign busy_o = busy_q && !wr_done;
  assign accept = start_i && !busy_o;

  // --------------------------------------------------------------------------
  // Job registers and busy
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
      go_q   <= 1'b0;
    end else begin
      go_q <= accept;
      if (accept) begin
        busy_q <= 1'b1;
      end else if (wr_done) begin
        busy_q <= 1'b0;
      end
    end
  end

  // Job fields stay put until the next accepted start
  always_ff @(posedge clk_i) begin
    if (accept) begin
      src_q <= src_addr_i;
      dst_q <= dst_addr_i;
      len_q <= len_i;
    end
  end

  copy_reader u_reader (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .start_i     (go_q),
    .src_addr_i  (src_q),
    .len_i       (len_q),
    .axi_req_o   (rd_req),
    .axi_resp_i  (rd_resp),
    .push_o      (push),
    .push_data_o (push_data),
    .full_i      (fifo_full),
    .rd_err_o    (rd_err)
  );

  copy_fifo u_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (push),
    .data_i  (push_data),
    .pop_i   (pop),
    .data_o  (pop_data),
    .empty_o (fifo_empty),
    .full_o  (fifo_full)
  );

  copy_writer u_writer (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .start_i    (go_q),
    .dst_addr_i (dst_q),
    .len_i      (len_q),
    .rd_err_i   (rd_err),
    .empty_i    (fifo_empty),
    .pop_o      (pop),
    .pop_data_i (pop_data),
    .axi_req_o  (wr_req),
    .axi_resp_i (wr_resp),
    .done_o     (wr_done),
    .err_o      (err_o)
  );

  assign done_o = wr_done;

  // Merge onto the single master port
  axi_rw_join #(
    .axi_req_t  (axi_req_t),
    .axi_resp_t (axi_resp_t)
  ) u_join (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .slv_read_req_i   (rd_req),
    .slv_read_resp_o  (rd_resp),
    .slv_write_req_i  (wr_req),
    .slv_write_resp_o (wr_resp),
    .mst_req_o        (mst_req_o),
    .mst_resp_i       (mst_resp_i)
  );

endmodule : axi_copy_top

// File: dv/tb_axi_mem.sv
/*
 * AXI memory model for the copy engine testbench with 64 KiB of words,
 * random ready/valid stalls, an SLVERR window and protocol checks
 */

`timescale 1ns/1ps

module tb_axi_mem import axi_copy_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  axi_req_t    req_i,
  output axi_resp_t   resp_o,
  output int unsigned err_count_o
);

  localparam axi_addr_t   ErrBase = 16'hF000;
  localparam int unsigned Words   = 16384;

  logic [31:0] mem_q [Words];
  int unsigned err_count = 0;

  // Read side state
  logic        ar_ready_q;
  logic        rd_busy_q;
  logic        r_valid_q;
  logic        r_last_q;
  logic [1:0]  ar_wait_q;
  logic [1:0]  r_wait_q;
  logic [1:0]  r_resp_q;
  axi_id_t     r_id_q;
  axi_addr_t   rd_addr_q;
  logic [8:0]  rd_left_q;
  logic [31:0] r_data_q;
  // Write side state
  logic        aw_ready_q;
  logic        wr_busy_q;
  logic        w_ready_q;
  logic        b_pend_q;
  logic        b_valid_q;
  logic        wr_err_q;
  logic [1:0]  aw_wait_q;
  logic [1:0]  w_wait_q;
  logic [1:0]  b_wait_q;
  logic [1:0]  b_resp_q;
  axi_id_t     b_id_q;
  axi_addr_t   wr_addr_q;
  logic [8:0]  wr_left_q;

  task automatic note_violation(input string msg);
    $display("[ERROR] %0t: %s", $time, msg);
    err_count++;
  endtask

  // Each word holds its own byte address XOR 0xA5A5
  initial begin
    for (int i = 0; i < Words; i++) begin
      mem_q[i] = 32'(i * 4) ^ 32'h0000_A5A5;
    end
  end

  // --------------------------------------------------------------------------
  // Read side with AR accept and one R beat per stall window
  // --------------------------------------------------------------------------
  always @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ar_ready_q <= 1'b0;
      rd_busy_q  <= 1'b0;
      r_valid_q  <= 1'b0;
      r_last_q   <= 1'b0;
      ar_wait_q  <= '0;
      r_wait_q   <= '0;
      r_resp_q   <= '0;
      r_id_q     <= '0;
      rd_addr_q  <= '0;
      rd_left_q  <= '0;
      r_data_q   <= '0;
    end else if (!rd_busy_q) begin
      if (ar_ready_q && req_i.ar_valid) begin
        ar_ready_q <= 1'b0;
        rd_busy_q  <= 1'b1;
        rd_addr_q  <= req_i.ar.addr;
        rd_left_q  <= 9'(req_i.ar.len) + 9'd1;
        r_id_q     <= req_i.ar.id;
        r_wait_q   <= 2'($urandom_range(0, 3));
      end else if (req_i.ar_valid && !ar_ready_q) begin
        if (ar_wait_q == 0) ar_ready_q <= 1'b1;
        else ar_wait_q <= ar_wait_q - 1'b1;
      end
    end else if (r_valid_q) begin
      if (req_i.r_ready) begin
        r_valid_q <= 1'b0;
        rd_addr_q <= rd_addr_q + 16'd4;
        rd_left_q <= rd_left_q - 1'b1;
        r_wait_q  <= 2'($urandom_range(0, 3));
        if (r_last_q) begin
          rd_busy_q <= 1'b0;
          ar_wait_q <= 2'($urandom_range(0, 3));
        end
      end
    end else if (r_wait_q != 0) begin
      r_wait_q <= r_wait_q - 1'b1;
    end else begin
      r_valid_q <= 1'b1;
      r_data_q  <= mem_q[rd_addr_q[AddrWidth-1:2]];
      r_resp_q  <= (rd_addr_q >= ErrBase) ? RespSlvErr : RespOkay;
      r_last_q  <= (rd_left_q == 9'd1);
    end
  end

  // --------------------------------------------------------------------------
  // Write side with AW accept, W beats and then B
  // --------------------------------------------------------------------------
  always @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      aw_ready_q <= 1'b0;
      wr_busy_q  <= 1'b0;
      w_ready_q  <= 1'b0;
      b_pend_q   <= 1'b0;
      b_valid_q  <= 1'b0;
      wr_err_q   <= 1'b0;
      aw_wait_q  <= '0;
      w_wait_q   <= '0;
      b_wait_q   <= '0;
      b_resp_q   <= '0;
      b_id_q     <= '0;
      wr_addr_q  <= '0;
      wr_left_q  <= '0;
    end else if (!wr_busy_q) begin
      if (aw_ready_q && req_i.aw_valid) begin
        aw_ready_q <= 1'b0;
        wr_busy_q  <= 1'b1;
        wr_err_q   <= 1'b0;
        wr_addr_q  <= req_i.aw.addr;
        wr_left_q  <= 9'(req_i.aw.len) + 9'd1;
        b_id_q     <= req_i.aw.id;
        w_wait_q   <= 2'($urandom_range(0, 3));
      end else if (req_i.aw_valid && !aw_ready_q) begin
        if (aw_wait_q == 0) aw_ready_q <= 1'b1;
        else aw_wait_q <= aw_wait_q - 1'b1;
      end
    end else if (!b_pend_q) begin
      if (w_ready_q && req_i.w_valid) begin
        // Last must sit exactly on the final beat of the AW burst
        assert (req_i.w.last == (wr_left_q == 9'd1))
          else note_violation($sformatf("W last %0b with %0d beats left", req_i.w.last,
                                        wr_left_q));
        assert (req_i.w.strb == 4'hF)
          else note_violation($sformatf("W strobe %h, expected all ones", req_i.w.strb));
        // Window writes are dropped
        if (wr_addr_q >= ErrBase) wr_err_q <= 1'b1;
        else mem_q[wr_addr_q[AddrWidth-1:2]] <= req_i.w.data;
        wr_addr_q <= wr_addr_q + 16'd4;
        wr_left_q <= wr_left_q - 1'b1;
        w_ready_q <= 1'b0;
        w_wait_q  <= 2'($urandom_range(0, 3));
        if (wr_left_q == 9'd1) begin
          b_pend_q <= 1'b1;
          b_wait_q <= 2'($urandom_range(0, 3));
        end
      end else if (req_i.w_valid && !w_ready_q) begin
        if (w_wait_q == 0) w_ready_q <= 1'b1;
        else w_wait_q <= w_wait_q - 1'b1;
      end
    end else if (b_valid_q) begin
      if (req_i.b_ready) begin
        b_valid_q <= 1'b0;
        b_pend_q  <= 1'b0;
        wr_busy_q <= 1'b0;
        aw_wait_q <= 2'($urandom_range(0, 3));
      end
    end else if (b_wait_q != 0) begin
      b_wait_q <= b_wait_q - 1'b1;
    end else begin
      b_valid_q <= 1'b1;
      b_resp_q  <= wr_err_q ? RespSlvErr : RespOkay;
    end
  end

  always_comb begin
    resp_o          = '0;
    resp_o.ar_ready = ar_ready_q;
    resp_o.r.id     = r_id_q;
    resp_o.r.data   = r_data_q;
    resp_o.r.resp   = r_resp_q;
    resp_o.r.last   = r_last_q;
    resp_o.r_valid  = r_valid_q;
    resp_o.aw_ready = aw_ready_q;
    resp_o.w_ready  = w_ready_q;
    resp_o.b.id     = b_id_q;
    resp_o.b.resp   = b_resp_q;
    resp_o.b_valid  = b_valid_q;
  end

  assign err_count_o = err_count;

  // Master side valids hold with a stable payload until ready
  ar_hold : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_i.ar_valid && !resp_o.ar_ready |=> req_i.ar_valid && $stable(req_i.ar))
    else note_violation("AR valid or payload changed before ready");
  aw_hold : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_i.aw_valid && !resp_o.aw_ready |=> req_i.aw_valid && $stable(req_i.aw))
    else note_violation("AW valid or payload changed before ready");
  w_hold : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_i.w_valid && !resp_o.w_ready |=> req_i.w_valid && $stable(req_i.w))
    else note_violation("W valid or payload changed before ready");

endmodule : tb_axi_mem

// File: dv/tb_axi_copy.sv
/*
 * Testbench top for the AXI copy engine with clock, reset, job stimulus,
 * completion and burst checks, per-test reporting and the timeout
 */

`timescale 1ns/1ps

module tb_axi_copy import axi_copy_pkg::*; ();

  localparam int unsigned NumTests      = 8;
  // Every beat of both channels can stall up to 4 cycles
  localparam int unsigned TimeoutCycles = NumTests * MaxBeats * 2 * 4 + 200;
  localparam axi_addr_t   IgnSrc        = 16'h0500;
  localparam axi_addr_t   IgnDst        = 16'h8400;

  logic        clk_i;
  logic        rst_n_i;
  logic        start_i;
  axi_addr_t   src_addr_i;
  axi_addr_t   dst_addr_i;
  axi_len_t    len_i;
  logic        busy_o;
  logic        done_o;
  logic        err_o;
  axi_req_t    mst_req;
  axi_resp_t   mst_resp;
  int unsigned mem_errors;

  // Expected job, set before each start
  axi_addr_t   exp_src;
  axi_addr_t   exp_dst;
  axi_len_t    exp_len;
  logic        job_open = 1'b0;
  // Running handshake totals
  int unsigned ar_total = 0;
  int unsigned aw_total = 0;
  int unsigned r_total = 0;
  int unsigned w_total = 0;
  int unsigned done_total = 0;
  int unsigned tb_errors = 0;
  int unsigned pass_cnt = 0;
  int unsigned fail_cnt = 0;
  int unsigned cycle_cnt = 0;
  axi_len_t    rand_len;

  axi_copy_top u_dut (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .start_i    (start_i),
    .src_addr_i (src_addr_i),
    .dst_addr_i (dst_addr_i),
    .len_i      (len_i),
    .busy_o     (busy_o),
    .done_o     (done_o),
    .err_o      (err_o),
    .mst_req_o  (mst_req),
    .mst_resp_i (mst_resp)
  );

  tb_axi_mem u_mem (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_i       (mst_req),
    .resp_o      (mst_resp),
    .err_count_o (mem_errors)
  );

  always #50 clk_i = ~clk_i;

  task automatic flag_error(input string msg);
    $display("[ERROR] %0t: %s", $time, msg);
    tb_errors++;
  endtask

  function automatic int unsigned total_errors();
    return tb_errors + mem_errors;
  endfunction

  // Preloaded memory word at a byte address
  function automatic logic [31:0] preload_word(input axi_addr_t addr);
    return 32'(addr) ^ 32'h0000_A5A5;
  endfunction

  task automatic report_test(input string name, input int unsigned errs_before);
    if (total_errors() == errs_before) begin
      $display("test %-12s passed", name);
      pass_cnt++;
    end else begin
      $display("test %-12s failed", name);
      fail_cnt++;
    end
  endtask

  task automatic check_idle_outputs();
    assert (!busy_o && !done_o && !err_o)
      else flag_error($sformatf("job outputs busy %b done %b err %b, expected 0",
                                busy_o, done_o, err_o));
    assert (!mst_req.ar_valid && !mst_req.aw_valid && !mst_req.w_valid &&
            !mst_req.r_ready && !mst_req.b_ready)
      else flag_error("AXI valids or readies high out of reset");
  endtask

  // --------------------------------------------------------------------------
  // One job with start, optional ignored start, wait for done and checks
  // --------------------------------------------------------------------------
  task automatic run_copy(input string name, input axi_addr_t src, input axi_addr_t dst,
                          input axi_len_t len, input logic exp_err, input logic poke_busy);
    int unsigned errs_before;
    int unsigned ar_before;
    int unsigned aw_before;
    int unsigned r_before;
    int unsigned w_before;
    int unsigned done_before;
    logic        got_err;
    errs_before = total_errors();
    while (busy_o) @(posedge clk_i);
    exp_src     = src;
    exp_dst     = dst;
    exp_len     = len;
    ar_before   = ar_total;
    aw_before   = aw_total;
    r_before    = r_total;
    w_before    = w_total;
    done_before = done_total;
    start_i    <= 1'b1;
    src_addr_i <= src;
    dst_addr_i <= dst;
    len_i      <= len;
    @(posedge clk_i);
    start_i <= 1'b0;
    // Second strobe lands while the long job is still busy
    if (poke_busy) begin
      repeat (3) @(posedge clk_i);
      start_i    <= 1'b1;
      src_addr_i <= IgnSrc;
      dst_addr_i <= IgnDst;
      len_i      <= 5'd4;
      @(posedge clk_i);
      start_i <= 1'b0;
    end
    do @(posedge clk_i); while (!done_o);
    got_err = err_o;
    // Let late handshakes or a stray done show up in the totals
    repeat (6) @(posedge clk_i);
    assert (ar_total - ar_before == 1 && aw_total - aw_before == 1)
      else flag_error($sformatf("saw %0d AR and %0d AW, expected one each",
                                ar_total - ar_before, aw_total - aw_before));
    assert (r_total - r_before == len && w_total - w_before == len)
      else flag_error($sformatf("saw %0d R and %0d W beats, expected %0d",
                                r_total - r_before, w_total - w_before, len));
    assert (done_total - done_before == 1)
      else flag_error($sformatf("saw %0d done strobes, expected 1", done_total - done_before));
    assert (got_err == exp_err)
      else flag_error($sformatf("err_o %b with done, expected %b", got_err, exp_err));
    if (!exp_err) begin
      for (int i = 0; i < len; i++) begin
        assert (u_mem.mem_q[int'(dst >> 2) + i] == preload_word(src + 16'(4 * i)))
          else flag_error($sformatf("dst word %0d is %h, expected %h", i,
                                    u_mem.mem_q[int'(dst >> 2) + i],
                                    preload_word(src + 16'(4 * i))));
      end
    end
    if (poke_busy) begin
      assert (u_mem.mem_q[int'(IgnDst >> 2)] == preload_word(IgnDst))
        else flag_error("ignored job wrote its destination");
    end
    report_test(name, errs_before);
  endtask

  // --------------------------------------------------------------------------
  // Monitor for job strobes, burst format and join idle channels
  // --------------------------------------------------------------------------
  always @(posedge clk_i) begin
    if (rst_n_i) begin
      if (job_open && !done_o) begin
        assert (busy_o) else flag_error("busy_o low while a job is running");
      end
      if (done_o) begin
        assert (!busy_o) else flag_error("busy_o still high in the done cycle");
      end
      if (!job_open) begin
        assert (!busy_o && !done_o) else flag_error("busy_o or done_o high with no job");
      end
      if (start_i && !busy_o) job_open <= 1'b1;
      else if (done_o) job_open <= 1'b0;
      if (done_o) done_total <= done_total + 1;
      // ID 1 for the reader and 2 for the writer
      // INCR is burst code 01 and size code 2 is four bytes
      if (mst_req.ar_valid && mst_resp.ar_ready) begin
        ar_total <= ar_total + 1;
        assert (mst_req.ar.id == 2'd1 && mst_req.ar.addr == exp_src &&
                mst_req.ar.len == 8'(exp_len) - 8'd1 &&
                mst_req.ar.size == 3'd2 && mst_req.ar.burst == 2'b01)
          else flag_error($sformatf("AR id %0d addr %h len %0d burst %0d, want %h len %0d",
                                    mst_req.ar.id, mst_req.ar.addr, mst_req.ar.len,
                                    mst_req.ar.burst, exp_src, exp_len - 1));
      end
      if (mst_req.aw_valid && mst_resp.aw_ready) begin
        aw_total <= aw_total + 1;
        assert (mst_req.aw.id == 2'd2 && mst_req.aw.addr == exp_dst &&
                mst_req.aw.len == 8'(exp_len) - 8'd1 &&
                mst_req.aw.size == 3'd2 && mst_req.aw.burst == 2'b01)
          else flag_error($sformatf("AW id %0d addr %h len %0d burst %0d, want %h len %0d",
                                    mst_req.aw.id, mst_req.aw.addr, mst_req.aw.len,
                                    mst_req.aw.burst, exp_dst, exp_len - 1));
      end
      if (mst_resp.r_valid && mst_req.r_ready) r_total <= r_total + 1;
      if (mst_req.w_valid && mst_resp.w_ready) w_total <= w_total + 1;
      // Join sides only drive their own channels
      assert (!u_dut.rd_req.aw_valid && !u_dut.rd_req.w_valid && !u_dut.rd_req.b_ready)
        else flag_error("read side of the join drives a write channel");
      assert (!u_dut.wr_req.ar_valid && !u_dut.wr_req.r_ready)
        else flag_error("write side of the join drives a read channel");
      assert (!u_dut.rd_resp.b_valid && !u_dut.rd_resp.aw_ready && !u_dut.rd_resp.w_ready &&
              !u_dut.wr_resp.r_valid && !u_dut.wr_resp.ar_ready)
        else flag_error("join forwards a response to the wrong side");
    end
  end

  // Run limit
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TimeoutCycles) begin
      $display("Timeout: run still going after %0d cycles", cycle_cnt);
      $display("TESTS FAILED");
      $finish;
    end
  end

  initial begin
    int unsigned errs_before;
    void'($urandom(53835));
    clk_i      = 1'b0;
    rst_n_i    = 1'b0;
    start_i    = 1'b0;
    src_addr_i = '0;
    dst_addr_i = '0;
    len_i      = '0;
    exp_src    = '0;
    exp_dst    = '0;
    exp_len    = '0;
    rand_len   = axi_len_t'($urandom_range(2, 15));

    errs_before = total_errors();
    repeat (5) @(posedge clk_i);
    check_idle_outputs();
    repeat (5) @(posedge clk_i);
    rst_n_i <= 1'b1;
    repeat (2) @(posedge clk_i);
    check_idle_outputs();
    report_test("reset_state", errs_before);

    run_copy("copy_len1", 16'h0100, 16'h8000, 5'd1, 1'b0, 1'b0);
    run_copy("copy_len16", 16'h0200, 16'h8100, 5'd16, 1'b0, 1'b0);
    run_copy("copy_rand", 16'h0300, 16'h8200, rand_len, 1'b0, 1'b0);
    run_copy("start_busy", 16'h0400, 16'h8300, 5'd16, 1'b0, 1'b1);
    run_copy("read_err", 16'hF000, 16'h8500, 5'd8, 1'b1, 1'b0);
    run_copy("write_err", 16'h0600, 16'hF100, 5'd8, 1'b1, 1'b0);
    run_copy("clean_after", 16'h0700, 16'h8600, 5'd12, 1'b0, 1'b0);

    $display("%0d tests: %0d passed, %0d failed, %0d errors",
             pass_cnt + fail_cnt, pass_cnt, fail_cnt, total_errors());
    if (fail_cnt == 0 && total_errors() == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule : tb_axi_copy

// File: vlog.f
design/axi_copy_pkg.sv
design/axi_rw_join.sv
design/copy_reader.sv
design/copy_fifo.sv
design/copy_writer.sv
design/axi_copy_top.sv
dv/tb_axi_mem.sv
dv/tb_axi_copy.sv

// File: Bender.yml
package:
  name: axi_copy

sources:
  - design/axi_copy_pkg.sv
  - design/axi_rw_join.sv
  - design/copy_reader.sv
  - design/copy_fifo.sv
  - design/copy_writer.sv
  - design/axi_copy_top.sv
  - target: simulation
    files:
      - dv/tb_axi_mem.sv
      - dv/tb_axi_copy.sv
